// File: verilog.f
+incdir+test
verilog/droop_pkg.sv
verilog/trig_sync.sv
verilog/anti_droop_iir.sv
verilog/droop_regs.sv
verilog/sat_counter.sv
verilog/droop_top.sv
test/droop_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the anti-droop front end

VERILATOR  ?= verilator
TOP        := droop_tb
RTL_TOP    := droop_top
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass only if the pass message shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: test/droop_model.svh
/*
  Reference model for one anti-droop channel
  Accumulator step, output saturation rule, counter step and register read-back
*/
`ifndef DROOP_MODEL_SVH
`define DROOP_MODEL_SVH

// Accumulator after one edge: cleared, or grown by sample times weight
function automatic logic signed [acc_w-1:0] acc_step(
  input logic signed [sample_w-1:0] sample,
  input logic signed [weight_w-1:0] weight,
  input logic                       clear,
  input logic signed [acc_w-1:0]    acc
);
  logic signed [acc_w-1:0] sample_x;
  logic signed [acc_w-1:0] weight_x;
  sample_x = acc_w'(sample);
  weight_x = acc_w'(weight);
  if (clear) begin
    return '0;
  end
  // 48-bit wrap, same as a hardware adder
  return acc + sample_x * weight_x;
endfunction

// Output sample from accumulator and delayed input
function automatic chan_out_t predict_output(
  input logic signed [acc_w-1:0]    acc,
  input logic signed [sample_w-1:0] sample,
  input int                         scale
);
  chan_out_t               res;
  logic signed [acc_w-1:0] top;
  logic signed [acc_w-1:0] shifted;
  // Everything above the kept slice, sign preserved
  top     = acc >>> (scale + sample_w - 1);
  shifted = acc >>> scale;
  if (top != '0 && top != '1) begin
    res.sat  = 1'b1;
    res.data = (acc < 0) ? sample_w'(-32768) : sample_w'(32767);
  end else begin
    res.sat = 1'b0;
    // Low 16 bits of the shifted accumulator, sum wraps
    res.data = sample + sample_w'(shifted);
  end
  return res;
endfunction

// Saturating counter, clear first
function automatic logic [satcnt_w-1:0] count_step(
  input logic [satcnt_w-1:0] count,
  input logic                sat,
  input logic                clear
);
  if (clear) begin
    return '0;
  end
  if (sat && count != {satcnt_w{1'b1}}) begin
    return count + satcnt_w'(1);
  end
  return count;
endfunction

// Expected read data for an address
function automatic logic [31:0] reg_read_value(
  input reg_addr_t                  addr,
  input logic signed [weight_w-1:0] w0,
  input logic signed [weight_w-1:0] w1,
  input logic [1:0]                 ctrl,
  input logic [satcnt_w-1:0]        cnt0,
  input logic [satcnt_w-1:0]        cnt1
);
  case (addr)
    addr_weight0: return w0;
    addr_weight1: return w1;
    addr_ctrl:    return {30'd0, ctrl};
    addr_satcnt0: return 32'(cnt0);
    addr_satcnt1: return 32'(cnt1);
    default:      return '0;
  endcase
endfunction

`endif

// File: test/droop_tb.sv
/*
  Testbench for the two-channel anti-droop front end
  LFSR stimulus and register traffic, checked every cycle against a cycle model
*/
`timescale 1ns/1ps

module droop_tb import droop_pkg::*; ();

  `include "droop_model.svh"

  localparam int iir_scale = 20;
  // Phase lengths in cycles
  // The register phase length is an estimate
  localparam int n_zero = 200;
  localparam int n_accum = 1000;
  localparam int n_sat = 800;
  localparam int n_trig = 1000;
  localparam int n_regs = 300;
  localparam int cycle_limit = (n_zero + n_accum + 2 * n_sat + n_trig + n_regs) * 3 / 2;
  localparam logic [31:0] big_weight = 32'h0010_0000;
  // Sample kinds
  localparam int smp_full = 0;
  localparam int smp_pos = 1;
  localparam int smp_neg = 2;

  logic                       clk;
  logic                       rst_n;
  logic                       trig;
  logic signed [sample_w-1:0] din0;
  logic signed [sample_w-1:0] din1;
  reg_addr_t                  reg_addr;
  logic [31:0]                reg_wdata;
  logic                       reg_wr;
  logic                       reg_rd;
  logic [31:0]                reg_rdata;
  logic                       reg_rvalid;
  chan_out_t                  out0;
  chan_out_t                  out1;

  // Model state
  logic [31:0]                lfsr;
  logic signed [acc_w-1:0]    m_acc [2];
  logic signed [weight_w-1:0] m_weight [2];
  logic [satcnt_w-1:0]        m_cnt [2];
  logic [1:0]                 m_ctrl;
  logic                       m_ta;
  logic                       m_tb;
  logic                       rd_pend;
  logic [31:0]                rd_exp;
  chan_out_t                  exp_q0 [$];
  chan_out_t                  exp_q1 [$];
  chan_out_t                  exp_out0;
  chan_out_t                  exp_out1;
  int                         err_out = 0;
  int                         err_reg = 0;
  int                         cycles = 0;

  droop_top #(.iir_scale(iir_scale)) dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .trig       (trig),
    .din0       (din0),
    .din1       (din1),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .out0       (out0),
    .out1       (out1)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  // Stepped once for every bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      bits = {bits[30:0], lfsr[0]};
    end
    return bits;
  endfunction

  // Signed 13-bit weight keeps the random walk inside the slice
  function automatic logic [31:0] small_weight();
    logic [31:0] bits;
    bits = take_bits(13);
    return {{19{bits[12]}}, bits[12:0]};
  endfunction

  function automatic logic signed [sample_w-1:0] next_sample(input int kind);
    logic [31:0] bits;
    bits = take_bits(kind == smp_full ? 16 : 14);
    case (kind)
      smp_pos: return {2'b01, bits[13:0]};
      smp_neg: return {2'b10, bits[13:0]};
      default: return bits[15:0];
    endcase
  endfunction

  // One sample per channel per cycle
  // Trigger is high from trig_at for trig_len cycles
  task automatic drive_samples(input int n, input int kind, input int trig_at, input int trig_len);
    for (int i = 0; i < n; i++) begin
      din0 <= next_sample(kind);
      din1 <= next_sample(kind);
      trig <= (i >= trig_at) && (i < trig_at + trig_len);
      @(posedge clk);
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input logic [31:0] data);
    reg_addr  <= addr;
    reg_wdata <= data;
    reg_wr    <= 1'b1;
    @(posedge clk);
    reg_wr <= 1'b0;
  endtask

  // Strobe one read and wait for the valid pulse that answers it
  task automatic read_reg(input reg_addr_t addr);
    reg_addr <= addr;
    reg_rd   <= 1'b1;
    @(posedge clk);
    reg_rd <= 1'b0;
    do @(posedge clk); while (reg_rvalid !== 1'b1);
  endtask

  // Cycle model reads DUT inputs and outputs as they stood before the edge
  always @(posedge clk) begin : model
    logic signed [sample_w-1:0] din_v [2];
    logic signed [weight_w-1:0] w_used [2];
    logic [1:0]                 clr_next;
    logic [1:0]                 cnt_clr;
    chan_out_t                  entry [2];
    din_v[0] = din0;
    din_v[1] = din1;
    if (!rst_n) begin
      for (int c = 0; c < 2; c++) begin
        m_acc[c]    = '0;
        m_weight[c] = '0;
        m_cnt[c]    = '0;
      end
      m_ctrl  = '0;
      m_ta    = 1'b0;
      m_tb    = 1'b0;
      rd_pend = 1'b0;
      rd_exp  = '0;
      // Two reset outputs still ahead of the first real one
      exp_q0.delete();
      exp_q1.delete();
      repeat (2) begin
        exp_q0.push_back('0);
        exp_q1.push_back('0);
      end
      exp_out0 <= '0;
      exp_out1 <= '0;
    end else begin
      assert (out0 == exp_out0) else begin
        err_out++;
        $display("** Error at %0t: out0 %0d sat %b, expected %0d sat %b",
                 $time, out0.data, out0.sat, exp_out0.data, exp_out0.sat);
      end
      assert (out1 == exp_out1) else begin
        err_out++;
        $display("** Error at %0t: out1 %0d sat %b, expected %0d sat %b",
                 $time, out1.data, out1.sat, exp_out1.data, exp_out1.sat);
      end
      if (rd_pend) begin
        assert (reg_rdata == rd_exp) else begin
          err_reg++;
          $display("** Error at %0t: reg_rdata %h, expected %h", $time, reg_rdata, rd_exp);
        end
      end
      rd_pend = reg_rd;
      if (reg_rd) begin
        rd_exp = reg_read_value(reg_addr, m_weight[0], m_weight[1], m_ctrl, m_cnt[0], m_cnt[1]);
      end
      // Counters see the outputs registered before this edge
      cnt_clr[0] = reg_wr && (reg_addr == addr_satcnt0);
      cnt_clr[1] = reg_wr && (reg_addr == addr_satcnt1);
      m_cnt[0] = count_step(m_cnt[0], exp_out0.sat, cnt_clr[0]);
      m_cnt[1] = count_step(m_cnt[1], exp_out1.sat, cnt_clr[1]);
      // Product takes the weight held before a write on this edge
      w_used[0] = m_weight[0];
      w_used[1] = m_weight[1];
      if (reg_wr) begin
        case (reg_addr)
          addr_weight0: m_weight[0] = reg_wdata;
          addr_weight1: m_weight[1] = reg_wdata;
          addr_ctrl:    m_ctrl = reg_wdata[1:0];
          default:      ;
        endcase
      end
      // Two-flop trigger copy whose edge acts on the accumulator one clock later
      m_tb = m_ta;
      m_ta = trig;
      clr_next = {2{m_ta & ~m_tb}} & m_ctrl;
      for (int c = 0; c < 2; c++) begin
        m_acc[c] = acc_step(din_v[c], w_used[c], clr_next[c], m_acc[c]);
        entry[c] = predict_output(m_acc[c], din_v[c], iir_scale);
      end
      exp_q0.push_back(entry[0]);
      exp_q1.push_back(entry[1]);
      exp_out0 <= exp_q0.pop_front();
      exp_out1 <= exp_q1.pop_front();
    end
  end

  // Valid exactly one cycle after the read strobe
  assert property (@(posedge clk) disable iff (!rst_n) reg_rvalid == $past(reg_rd))
    else begin
      err_reg++;
      $display("** Error at %0t: reg_rvalid did not follow reg_rd by one cycle", $time);
    end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    lfsr      = 32'hde6b;
    rst_n     = 1'b0;
    trig      = 1'b0;
    din0      = '0;
    din1      = '0;
    reg_addr  = '0;
    reg_wdata = '0;
    reg_wr    = 1'b0;
    reg_rd    = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    // Zero weights pass the input through three cycles late
    drive_samples(n_zero, smp_full, 0, 0);
    // Different small weights per channel
    write_reg(addr_weight0, small_weight());
    write_reg(addr_weight1, small_weight());
    drive_samples(n_accum, smp_full, 0, 0);
    // Both channels cleared at the start of each polarity
    write_reg(addr_ctrl, 32'd3);
    write_reg(addr_weight0, big_weight);
    write_reg(addr_weight1, big_weight);
    drive_samples(n_sat, smp_pos, 0, 2);
    drive_samples(n_sat, smp_neg, 0, 2);
    // Fresh start on both channels
    write_reg(addr_weight0, small_weight());
    write_reg(addr_weight1, small_weight());
    drive_samples(8, smp_full, 0, 2);
    // Clear on channel 0 only with a long and a short trigger
    write_reg(addr_ctrl, 32'd1);
    drive_samples(n_trig / 2, smp_full, 100, 300);
    drive_samples(n_trig / 2, smp_full, 100, 40);
    // Read-back, unmapped space and counter clears
    write_reg(addr_weight0, 32'hfff0_1234);
    read_reg(addr_weight0);
    write_reg(addr_weight1, 32'h0000_0a5c);
    read_reg(addr_weight1);
    read_reg(addr_ctrl);
    write_reg(3'd5, 32'hffff_ffff);
    read_reg(3'd5);
    read_reg(3'd7);
    read_reg(addr_satcnt0);
    read_reg(addr_satcnt1);
    write_reg(addr_satcnt0, 32'd0);
    read_reg(addr_satcnt0);
    write_reg(addr_weight0, big_weight);
    drive_samples(40, smp_pos, 0, 0);
    read_reg(addr_satcnt0);
    write_reg(addr_satcnt1, 32'd0);
    read_reg(addr_satcnt1);
    repeat (6) @(posedge clk);
    // Let the checks of the last edge finish before the counts are read
    @(negedge clk);
    $display("Errors: %0d output, %0d register", err_out, err_reg);
    if (err_out == 0 && err_reg == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog/droop_top.sv
/*
  Two-channel anti-droop correction front end
  Shared trigger sync, register block, two filter channels and saturation counters
*/
`timescale 1ns/1ps

module droop_top import droop_pkg::*; #(
  parameter int iir_scale = 20
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       trig,
  input  logic signed [sample_w-1:0] din0,
  input  logic signed [sample_w-1:0] din1,
  input  reg_addr_t                  reg_addr,
  input  logic [31:0]                reg_wdata,
  input  logic                       reg_wr,
  input  logic                       reg_rd,
  output logic [31:0]                reg_rdata,
  output logic                       reg_rvalid,
  output chan_out_t                  out0,
  output chan_out_t                  out1
);

  logic                trig_edge;
  chan_cfg_t           cfg0;
  chan_cfg_t           cfg1;
  logic [satcnt_w-1:0] satcnt0;
  logic [satcnt_w-1:0] satcnt1;
  logic                satclr0;
  logic                satclr1;

  // One synchronizer so both channels clear on the same cycle
  trig_sync u_trig_sync (
    .clk       (clk),
    .rst_n     (rst_n),
    .trig      (trig),
    .trig_edge (trig_edge)
  );

  droop_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_wr     (reg_wr),
    .reg_rd     (reg_rd),
    .reg_rdata  (reg_rdata),
    .reg_rvalid (reg_rvalid),
    .cfg0       (cfg0),
    .cfg1       (cfg1),
    .satcnt0    (satcnt0),
    .satcnt1    (satcnt1),
    .satclr0    (satclr0),
    .satclr1    (satclr1)
  );

  // Channel 0
  anti_droop_iir #(.iir_scale(iir_scale)) u_iir0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .din       (din0),
    .trig_edge (trig_edge),
    .cfg       (cfg0),
    .dout      (out0)
  );

  sat_counter u_satcnt0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .sample (out0),
    .clr    (satclr0),
    .count  (satcnt0)
  );

  // Channel 1
  anti_droop_iir #(.iir_scale(iir_scale)) u_iir1 (
    .clk       (clk),
    .rst_n     (rst_n),
    .din       (din1),
    .trig_edge (trig_edge),
    .cfg       (cfg1),
    .dout      (out1)
  );

  sat_counter u_satcnt1 (
    .clk    (clk),
    .rst_n  (rst_n),
    .sample (out1),
    .clr    (satclr1),
    .count  (satcnt1)
  );

endmodule

// File: verilog/sat_counter.sv
/*
  Saturation counter
  Counts saturated output samples, sticks at full scale, clears on a pulse
*/
`timescale 1ns/1ps

module sat_counter import droop_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  chan_out_t           sample,
  input  logic                clr,
  output logic [satcnt_w-1:0] count
);

  // All ones means the counter is pinned
  logic at_max;

  assign at_max = &count;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clr) begin
      // Clear wins over a same-cycle increment
      count <= '0;
    end else if (sample.sat && !at_max) begin
      count <= count + 1'b1;
    end
  end

endmodule

// File: verilog/droop_regs.sv
/*
  Register block for the anti-droop front end
  Tap weights, clear enables and counter read-back behind write and read strobes
*/
`timescale 1ns/1ps

module droop_regs import droop_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  reg_addr_t           reg_addr,
  input  logic [31:0]         reg_wdata,
  input  logic                reg_wr,
  input  logic                reg_rd,
  output logic [31:0]         reg_rdata,
  output logic                reg_rvalid,
  output chan_cfg_t           cfg0,
  output chan_cfg_t           cfg1,
  input  logic [satcnt_w-1:0] satcnt0,
  input  logic [satcnt_w-1:0] satcnt1,
  output logic                satclr0,
  output logic                satclr1
);

  logic signed [weight_w-1:0] weight0;
  logic signed [weight_w-1:0] weight1;
  // Per-channel clear enables
  logic [1:0]                 ctrl;
  logic [31:0]                rd_mux;

  // Write decode; unmapped addresses fall through untouched
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      weight0 <= '0;
      weight1 <= '0;
      ctrl    <= '0;
    end else if (reg_wr) begin
      case (reg_addr)
        addr_weight0: weight0 <= reg_wdata;
        addr_weight1: weight1 <= reg_wdata;
        addr_ctrl:    ctrl    <= reg_wdata[1:0];
        default:      ;
      endcase
    end
  end

  // Counter clears land on the same edge as the write
  assign satclr0 = reg_wr && (reg_addr == addr_satcnt0);
  assign satclr1 = reg_wr && (reg_addr == addr_satcnt1);

  // Read mux, counters zero-extended
  always_comb begin
    rd_mux = '0;
    case (reg_addr)
      addr_weight0: rd_mux = weight0;
      addr_weight1: rd_mux = weight1;
      addr_ctrl:    rd_mux = {30'd0, ctrl};
      addr_satcnt0: rd_mux = {{(32 - satcnt_w){1'b0}}, satcnt0};
      addr_satcnt1: rd_mux = {{(32 - satcnt_w){1'b0}}, satcnt1};
      default:      rd_mux = '0;
    endcase
  end

  // Read data and valid one cycle after the strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_rdata  <= '0;
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= reg_rd;
      if (reg_rd) begin
        reg_rdata <= rd_mux;
      end
    end
  end

  // Channel settings out to the filters
  assign cfg0 = '{weight: weight0, clr_en: ctrl[0]};
  assign cfg1 = '{weight: weight1, clr_en: ctrl[1]};

endmodule

// File: verilog/anti_droop_iir.sv
/*
  Anti-droop correction channel
  Weighted accumulation of the input, scaled add-back and 16-bit saturation
*/
`timescale 1ns/1ps

module anti_droop_iir import droop_pkg::*; #(
  parameter int iir_scale = 20
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic signed [sample_w-1:0] din,
  input  logic                       trig_edge,
  input  chan_cfg_t                  cfg,
  output chan_out_t                  dout
);

  // Width of the accumulator bits above the kept slice, sign included
  localparam int top_w = acc_w - iir_scale - 15;

  // Stage 1, sample and product
  logic signed [sample_w-1:0] din_d1;
  logic signed [acc_w-1:0]    prod;

  // Stage 2, accumulator and aligned sample
  logic signed [sample_w-1:0] din_d2;
  logic signed [acc_w-1:0]    acc;
  logic                       acc_clr;

  // Stage 3 inputs, formed from the stage 2 registers
  logic [top_w-1:0]           acc_top;
  logic signed [sample_w-1:0] acc_slice;
  logic signed [sample_w-1:0] sum;
  logic                       ovf;
  logic signed [sample_w-1:0] sat_val;

  // Stage 1
  // 16 x 32 signed product fits the 48-bit accumulator exactly
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      din_d1 <= '0;
      prod   <= '0;
    end else begin
      din_d1 <= din;
      prod   <= din * $signed(cfg.weight);
    end
  end

  // Clear only on the synchronized trigger edge and only when enabled
  assign acc_clr = trig_edge & cfg.clr_en;

  // Stage 2
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      din_d2 <= '0;
      acc    <= '0;
    end else begin
      din_d2 <= din_d1;
      if (acc_clr) begin
        acc <= '0;
      end else begin
        acc <= acc + prod;
      end
    end
  end

  // Bits 47 down to scale+15 must all match the sign, else the slice overflows
  assign acc_top = acc[acc_w-1:iir_scale+15];
  assign ovf     = ~(&acc_top) & (|acc_top);

  // Kept slice of the accumulator, read as a signed correction term
  assign acc_slice = $signed(acc[iir_scale+15:iir_scale]);

  // Baseline restore; wraps in 16 bits when not saturating
  assign sum = din_d2 + acc_slice;

  // Clip value picked by the accumulator sign
  assign sat_val = acc[acc_w-1] ? 16'sh8000 : 16'sh7fff;

  // Stage 3
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dout <= '0;
    end else if (ovf) begin
      dout.data <= sat_val;
      dout.sat  <= 1'b1;
    end else begin
      dout.data <= sum;
      dout.sat  <= 1'b0;
    end
  end

endmodule

// File: verilog/trig_sync.sv
/*
  Trigger synchronizer
  Brings the async trigger level into clk and emits a one-cycle rising-edge pulse
*/
`timescale 1ns/1ps

module trig_sync (
  input  logic clk,
  input  logic rst_n,
  input  logic trig,
  output logic trig_edge
);

  // First flop may go metastable, second one settles it
  logic trig_a;
  logic trig_b;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trig_a <= 1'b0;
      trig_b <= 1'b0;
    end else begin
      trig_a <= trig;
      trig_b <= trig_a;
    end
  end

  // Level just went high on the synchronized side
  // A held trigger gives no further pulse
  assign trig_edge = trig_a & ~trig_b;

endmodule

// File: verilog/droop_pkg.sv
/*
  Anti-droop front end shared definitions
  Data widths, register map and the structs that cross module boundaries
*/
package droop_pkg;

  // ADC sample and corrected output width
  localparam int sample_w = 16;

  // Programmable tap weight width
  localparam int weight_w = 32;

  // Accumulator holds the full sample by weight product
  localparam int acc_w = sample_w + weight_w;

  // Saturation counter width
  localparam int satcnt_w = 16;

  // Register address space
  typedef logic [2:0] reg_addr_t;

  localparam reg_addr_t addr_weight0 = 3'd0;
  localparam reg_addr_t addr_weight1 = 3'd1;
  // Bit 0 clears channel 0 on trigger, bit 1 channel 1
  localparam reg_addr_t addr_ctrl    = 3'd2;
  // Read returns the count, a write clears it
  localparam reg_addr_t addr_satcnt0 = 3'd3;
  localparam reg_addr_t addr_satcnt1 = 3'd4;

  // Settings for one filter channel
  typedef struct packed {
    logic signed [weight_w-1:0] weight;
    logic                       clr_en;
  } chan_cfg_t;

  // One corrected output sample with its saturation flag
  typedef struct packed {
    logic signed [sample_w-1:0] data;
    logic                       sat;
  } chan_out_t;

endpackage
